/* build.f */
+incdir+hdl
hdl/zx_pkg.sv
hdl/clock_gen.sv
hdl/zsignals.sv
hdl/zports.sv
hdl/sound.sv
hdl/zx_top.sv
test/zx_top_sva.sv
test/tb_zx_top.sv

/* hdl/clock_gen.sv */
`timescale 1ns/1ps

`include "zx_config.svh"

module clock_gen (
	input  logic           fclk,
	input  logic           rst,
	input  zx_pkg::turbo_t turbo,
	output logic           f0,
	output logic           clkz_out
);

	localparam int CNT_W = `ZX_TURBO_CNT_W;

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] reload;

	// half-period minus one for the selected rate
	always_comb begin
		case (turbo)
			2'd0: begin
				reload = CNT_W'(`ZX_TURBO_DIV0 - 1);
			end
			2'd1: begin
				reload = CNT_W'(`ZX_TURBO_DIV1 - 1);
			end
			default: begin
				reload = CNT_W'(`ZX_TURBO_DIV2 - 1);
			end
		endcase
	end

	////////////////////
	// cpu clock
	////////////////////

	// turbo is only sampled on reload
	// so a new rate starts with the next half-period
	always_ff @(posedge fclk) begin
		if (rst) begin
			cnt      <= '0;
			clkz_out <= 1'b0;
		end else if (cnt == '0) begin
			cnt      <= reload;
			clkz_out <= ~clkz_out;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	////////////////////
	// sound strobe
	////////////////////

	// high every other fclk cycle
	always_ff @(posedge fclk) begin
		if (rst) begin
			f0 <= 1'b0;
		end else begin
			f0 <= ~f0;
		end
	end

endmodule

/* hdl/sound.sv */
`timescale 1ns/1ps

module sound (
	input  logic           fclk,
	input  logic           rst,
	input  logic           f0,
	input  logic           beeper_mux,
	input  logic           beeper_bit,
	input  zx_pkg::zdata_t covox_data,
	output logic           beep
);

	// bit 8 holds the carry of the last add
	logic [8:0] acc;
	logic       sd_bit;

	////////////////////
	// sigma-delta
	////////////////////

	// first order modulator stepped at the f0 rate
	// carry density is covox_data over 256
	always_ff @(posedge fclk) begin
		if (rst) begin
			acc <= '0;
		end else if (f0) begin
			acc <= {1'b0, acc[7:0]} + {1'b0, covox_data};
		end
	end

	assign sd_bit = acc[8];

	////////////////////
	// output
	////////////////////

	// beeper mode follows the port bit every cycle
	always_ff @(posedge fclk) begin
		if (rst) begin
			beep <= 1'b0;
		end else if (beeper_mux) begin
			beep <= sd_bit;
		end else begin
			beep <= beeper_bit;
		end
	end

endmodule

/* hdl/zports.sv */
`timescale 1ns/1ps

`include "zx_config.svh"

module zports (
	input  logic            fclk,
	input  logic            rst,
	input  zx_pkg::zaddr_t  a,
	input  zx_pkg::zdata_t  d_in,
	input  logic            iord,
	input  logic            iowr_s,
	output zx_pkg::zdata_t  d_out,
	output logic            d_ena,
	output zx_pkg::border_t border,
	output zx_pkg::turbo_t  turbo,
	output logic            beeper_mux,
	output logic            beeper_bit,
	output zx_pkg::zdata_t  covox_data
);

	logic [7:0] loa;
	logic [7:0] hia;

	logic port_xt;
	logic hit_border;
	logic hit_sysconf;
	logic hit_fe;
	logic hit_covox;

	logic border_wr;
	logic sysconf_wr;
	logic zborder_wr;
	logic covox_wr;

	zx_pkg::zdata_t sysconf;

	////////////////////
	// address decode
	////////////////////

	assign loa = a[7:0];
	assign hia = a[15:8];

	// extended ports share low byte AF
	assign port_xt     = (loa == `ZX_PORT_XT);
	assign hit_border  = port_xt & (hia == `ZX_REG_BORDER);
	assign hit_sysconf = port_xt & (hia == `ZX_REG_SYSCONF);

	// classic ports ignore the high byte
	assign hit_fe    = (loa == `ZX_PORT_FE);
	assign hit_covox = (loa == `ZX_PORT_COVOX);

	assign border_wr  = iowr_s & hit_border;
	assign sysconf_wr = iowr_s & hit_sysconf;
	assign zborder_wr = iowr_s & hit_fe;
	assign covox_wr   = iowr_s & hit_covox;

	////////////////////
	// registers
	////////////////////

	// full byte from port AF, or the 3-bit colour from FE
	always_ff @(posedge fclk) begin
		if (rst) begin
			border <= '0;
		end else if (border_wr) begin
			border <= zx_pkg::border_t'(d_in);
		end else if (zborder_wr) begin
			border <= {`ZX_ZBORDER_HIGH, d_in[2:0]};
		end
	end

	always_ff @(posedge fclk) begin
		if (rst) begin
			sysconf <= '0;
		end else if (sysconf_wr) begin
			sysconf <= d_in;
		end
	end

	// beeper bit comes with every FE write
	always_ff @(posedge fclk) begin
		if (rst) begin
			beeper_bit <= 1'b0;
		end else if (zborder_wr) begin
			beeper_bit <= d_in[`ZX_BEEPER_BIT];
		end
	end

	always_ff @(posedge fclk) begin
		if (rst) begin
			covox_data <= '0;
		end else if (covox_wr) begin
			covox_data <= d_in;
		end
	end

	// sysconf fields
	assign turbo      = sysconf[`ZX_SYSCONF_TURBO_HI:`ZX_SYSCONF_TURBO_LO];
	assign beeper_mux = sysconf[`ZX_SYSCONF_MUX_BIT];

	////////////////////
	// read-back
	////////////////////

	// only the two extended registers answer a read
	always_comb begin
		d_ena = iord & (hit_border | hit_sysconf);
		if (hit_border) begin
			d_out = zx_pkg::zdata_t'(border);
		end else begin
			d_out = sysconf;
		end
	end

endmodule

/* hdl/zsignals.sv */
`timescale 1ns/1ps

module zsignals #(
	parameter int SYNC_STAGES = 2
) (
	input  logic fclk,
	input  logic rst,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,
	output logic iord,
	output logic iowr_s
);

	// strobe positions in the synchronizer vector
	localparam int B_IORQ = 0;
	localparam int B_RD   = 1;
	localparam int B_WR   = 2;
	localparam int B_M1   = 3;
	localparam int NSTB   = 4;

	logic [NSTB-1:0] stb_raw_n;
	logic [NSTB-1:0] sync_q [SYNC_STAGES];
	logic [NSTB-1:0] stb_n;

	logic iorq;
	logic rd;
	logic wr;
	logic m1;
	logic iowr;
	logic iowr_hist;

	assign stb_raw_n = {m1_n, wr_n, rd_n, iorq_n};

	////////////////////
	// synchronizers
	////////////////////

	// chains come out of reset with every strobe idle
	always_ff @(posedge fclk) begin
		if (rst) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= '1;
			end
		end else begin
			sync_q[0] <= stb_raw_n;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign stb_n = sync_q[SYNC_STAGES-1];

	// active high levels in the fclk domain
	assign iorq = ~stb_n[B_IORQ];
	assign rd   = ~stb_n[B_RD];
	assign wr   = ~stb_n[B_WR];
	assign m1   = ~stb_n[B_M1];

	////////////////////
	// io cycle decode
	////////////////////

	// m1 with iorq is an interrupt acknowledge, not a port access
	assign iord = iorq & rd & ~m1;
	assign iowr = iorq & wr & ~m1;

	always_ff @(posedge fclk) begin
		if (rst) begin
			iowr_hist <= 1'b0;
		end else begin
			iowr_hist <= iowr;
		end
	end

	// one cycle at the start of the write
	assign iowr_s = iowr & ~iowr_hist;

endmodule

/* hdl/zx_config.svh */
`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

// low address bytes of the decoded ports
`define ZX_PORT_XT          8'hAF
`define ZX_PORT_FE          8'hFE
`define ZX_PORT_COVOX       8'hFB

// extended registers behind port AF
// the high address byte picks the register
`define ZX_REG_BORDER       8'h0F
`define ZX_REG_SYSCONF      8'h20

// port FE fields
`define ZX_ZBORDER_HIGH     5'b11110
`define ZX_BEEPER_BIT       4

// sysconf fields
`define ZX_SYSCONF_MUX_BIT  2
`define ZX_SYSCONF_TURBO_HI 1
`define ZX_SYSCONF_TURBO_LO 0

// clkz_out half-periods in fclk cycles
`define ZX_TURBO_DIV0       4
`define ZX_TURBO_DIV1       2
`define ZX_TURBO_DIV2       1

// half-period counter width
`define ZX_TURBO_CNT_W      3

`endif

/* hdl/zx_pkg.sv */
package zx_pkg;

	// z80 address bus
	typedef logic [15:0] zaddr_t;

	// z80 data byte, also sysconf and covox sample
	typedef logic [7:0] zdata_t;

	// border colour as held for the video side
	typedef logic [7:0] border_t;

	// cpu clock rate select
	// values 2 and 3 both give the fastest rate
	typedef logic [1:0] turbo_t;

endpackage

/* hdl/zx_top.sv */
`timescale 1ns/1ps

module zx_top (
	// clock and reset
	input  logic            fclk,
	input  logic            rst,

	// z80 bus
	input  zx_pkg::zaddr_t  a,
	input  zx_pkg::zdata_t  d_in,
	output zx_pkg::zdata_t  d_out,
	output logic            d_ena,
	input  logic            iorq_n,
	input  logic            rd_n,
	input  logic            wr_n,
	input  logic            m1_n,

	// cpu clock
	output logic            clkz_out,

	// video and sound
	output zx_pkg::border_t border,
	output logic            beep
);

	// bus strobes in the fclk domain
	logic iord;
	logic iowr_s;

	// configuration from the port registers
	zx_pkg::turbo_t turbo;
	logic           beeper_mux;
	logic           beeper_bit;
	zx_pkg::zdata_t covox_data;

	// sound strobe
	logic f0;

	////////////////////
	// clocks
	////////////////////

	clock_gen clock_gen_i (
		.fclk     (fclk),
		.rst      (rst),
		.turbo    (turbo),
		.f0       (f0),
		.clkz_out (clkz_out)
	);

	////////////////////
	// z80 interface
	////////////////////

	zsignals #(
		.SYNC_STAGES (2)
	) zsignals_i (
		.fclk   (fclk),
		.rst    (rst),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.iord   (iord),
		.iowr_s (iowr_s)
	);

	zports zports_i (
		.fclk       (fclk),
		.rst        (rst),
		.a          (a),
		.d_in       (d_in),
		.iord       (iord),
		.iowr_s     (iowr_s),
		.d_out      (d_out),
		.d_ena      (d_ena),
		.border     (border),
		.turbo      (turbo),
		.beeper_mux (beeper_mux),
		.beeper_bit (beeper_bit),
		.covox_data (covox_data)
	);

	////////////////////
	// beeper and covox
	////////////////////

	sound sound_i (
		.fclk       (fclk),
		.rst        (rst),
		.f0         (f0),
		.beeper_mux (beeper_mux),
		.beeper_bit (beeper_bit),
		.covox_data (covox_data),
		.beep       (beep)
	);

endmodule

/* run.sh */
#!/bin/sh
# compile and run the zx_top testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_zx_top -Mdir obj_dir -o sim_zx
./obj_dir/sim_zx > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
	echo "simulation ok"
else
	echo "simulation reported errors, see sim.log"
	exit 1
fi

/* test/tb_zx_top.sv */
`timescale 1ns/1ps

`include "zx_config.svh"

module tb_zx_top;

	// roughly 1800 cycles of tests
	localparam int CYCLE_LIMIT  = 6000;
	localparam int COVOX_WINDOW = 512;

	localparam zx_pkg::zaddr_t ADDR_BORDER  = {`ZX_REG_BORDER, `ZX_PORT_XT};
	localparam zx_pkg::zaddr_t ADDR_SYSCONF = {`ZX_REG_SYSCONF, `ZX_PORT_XT};
	localparam zx_pkg::zaddr_t ADDR_FE      = {8'h00, `ZX_PORT_FE};
	localparam zx_pkg::zaddr_t ADDR_COVOX   = {8'h00, `ZX_PORT_COVOX};
	localparam zx_pkg::zaddr_t ADDR_UNUSED  = 16'h10AF;
	localparam zx_pkg::zdata_t SYSCONF_MUX  = 8'(1 << `ZX_SYSCONF_MUX_BIT);

	logic            fclk;
	logic            rst;
	zx_pkg::zaddr_t  a;
	zx_pkg::zdata_t  d_in;
	zx_pkg::zdata_t  d_out;
	logic            d_ena;
	logic            iorq_n;
	logic            rd_n;
	logic            wr_n;
	logic            m1_n;
	logic            clkz_out;
	zx_pkg::border_t border;
	logic            beep;

	// register model
	zx_pkg::border_t m_border;
	zx_pkg::zdata_t  m_sysconf;
	logic            m_beeper;
	zx_pkg::zdata_t  m_covox;

	logic [15:0] lfsr;
	int          errors = 0;
	int          test_errs;
	int          n_tests;
	int          n_bad;
	int          idle_cnt = 0;
	logic        run_checks = 1'b0;

	zx_top dut_i (
		.fclk     (fclk),
		.rst      (rst),
		.a        (a),
		.d_in     (d_in),
		.d_out    (d_out),
		.d_ena    (d_ena),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.clkz_out (clkz_out),
		.border   (border),
		.beep     (beep)
	);

	always #2 fclk = ~fclk;

	////////////////////
	// reference model
	////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// applies one port access, returns {d_ena, d_out} for reads
	function automatic logic [8:0] model_access(input zx_pkg::zaddr_t addr,
			input zx_pkg::zdata_t data, input logic write, input logic m1);
		logic [7:0] lo;
		logic [7:0] hi;
		logic [8:0] rsp;
		lo  = addr[7:0];
		hi  = addr[15:8];
		rsp = '0;
		// m1 cycles are not port accesses
		if (!m1) begin
			if (write) begin
				if (lo == `ZX_PORT_XT && hi == `ZX_REG_BORDER) begin
					m_border = zx_pkg::border_t'(data);
				end else if (lo == `ZX_PORT_XT && hi == `ZX_REG_SYSCONF) begin
					m_sysconf = data;
				end else if (lo == `ZX_PORT_FE) begin
					m_border = {`ZX_ZBORDER_HIGH, data[2:0]};
					m_beeper = data[`ZX_BEEPER_BIT];
				end else if (lo == `ZX_PORT_COVOX) begin
					m_covox = data;
				end
			end else if (lo == `ZX_PORT_XT && hi == `ZX_REG_BORDER) begin
				rsp = {1'b1, m_border};
			end else if (lo == `ZX_PORT_XT && hi == `ZX_REG_SYSCONF) begin
				rsp = {1'b1, m_sysconf};
			end
		end
		return rsp;
	endfunction

	function automatic int ref_half(input zx_pkg::turbo_t t);
		case (t)
			2'd0: return `ZX_TURBO_DIV0;
			2'd1: return `ZX_TURBO_DIV1;
			default: return `ZX_TURBO_DIV2;
		endcase
	endfunction

	////////////////////
	// checks
	////////////////////

	task automatic check_data(input string name, input zx_pkg::zdata_t got,
			input zx_pkg::zdata_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_border(input string name, input zx_pkg::border_t got,
			input zx_pkg::border_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// idle bus never drives data, border always matches the model
	always @(negedge fclk) begin
		if (iorq_n & rd_n & wr_n & m1_n) begin
			idle_cnt++;
		end else begin
			idle_cnt = 0;
		end
		if (run_checks && idle_cnt >= 3) begin
			check_bit("d_ena", d_ena, 1'b0);
			check_border("border", border, m_border);
		end
	end

	////////////////////
	// bus access
	////////////////////

	task automatic rand_byte(output zx_pkg::zdata_t v);
		v = '0;
		for (int i = 0; i < 8; i++) begin
			v    = {v[6:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// strobes low for 6 cycles, then idle for 4
	task automatic bus_cycle(input zx_pkg::zaddr_t addr, input zx_pkg::zdata_t data,
			input logic write, input logic m1, output zx_pkg::zdata_t got_data,
			output logic got_ena, output logic [8:0] exp_rsp);
		@(posedge fclk);
		#1;
		a      = addr;
		d_in   = data;
		iorq_n = 1'b0;
		rd_n   = write;
		wr_n   = ~write;
		m1_n   = ~m1;
		repeat (4) @(posedge fclk);
		@(negedge fclk);
		got_data = d_out;
		got_ena  = d_ena;
		repeat (2) @(posedge fclk);
		#1;
		iorq_n  = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		m1_n    = 1'b1;
		exp_rsp = model_access(addr, data, write, m1);
		repeat (3) @(posedge fclk);
	endtask

	task automatic io_write(input zx_pkg::zaddr_t addr, input zx_pkg::zdata_t data,
			input logic m1);
		zx_pkg::zdata_t got;
		logic           ena;
		logic [8:0]     rsp;
		bus_cycle(addr, data, 1'b1, m1, got, ena, rsp);
	endtask

	task automatic io_read(input zx_pkg::zaddr_t addr, input logic m1);
		zx_pkg::zdata_t got;
		logic           ena;
		logic [8:0]     rsp;
		bus_cycle(addr, 8'h00, 1'b0, m1, got, ena, rsp);
		check_bit("d_ena", ena, rsp[8]);
		if (rsp[8]) begin
			check_data("d_out", got, rsp[7:0]);
		end
	endtask

	task automatic wait_clkz_edge();
		logic prev;
		@(negedge fclk);
		prev = clkz_out;
		do begin
			@(negedge fclk);
		end while (clkz_out == prev);
	endtask

	task automatic check_clkz(input zx_pkg::turbo_t t);
		int   half;
		logic lvl;
		half = ref_half(t);
		io_write(ADDR_SYSCONF, zx_pkg::zdata_t'(t), 1'b0);
		// new rate starts at the next toggle
		wait_clkz_edge();
		wait_clkz_edge();
		lvl = clkz_out;
		for (int i = 1; i < 4 * half; i++) begin
			@(negedge fclk);
			check_bit("clkz_out", clkz_out, lvl ^ ((i / half) % 2 == 1));
		end
	endtask

	task automatic check_covox(input zx_pkg::zdata_t v);
		int highs;
		int exp_highs;
		io_write(ADDR_SYSCONF, SYSCONF_MUX, 1'b0);
		io_write(ADDR_COVOX, v, 1'b0);
		repeat (8) @(negedge fclk);
		highs     = 0;
		exp_highs = COVOX_WINDOW * int'(m_covox) / 256;
		for (int i = 0; i < COVOX_WINDOW; i++) begin
			@(negedge fclk);
			if (beep) begin
				highs++;
			end
		end
		if (highs < exp_highs - 2 || highs > exp_highs + 2) begin
			errors++;
			$display("covox %h: beep high for %0d cycles, expected about %0d",
				v, highs, exp_highs);
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (errors == test_errs) begin
			$display("test %-10s ok", name);
		end else begin
			n_bad++;
			$display("test %-10s %0d errors", name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		zx_pkg::zdata_t v;
		fclk      = 1'b0;
		rst       = 1'b1;
		a         = '0;
		d_in      = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		m1_n      = 1'b1;
		m_border  = '0;
		m_sysconf = '0;
		m_beeper  = 1'b0;
		m_covox   = '0;
		lfsr      = 16'd29;
		test_errs = 0;
		n_tests   = 0;
		n_bad     = 0;
		repeat (2) @(posedge fclk);
		#1;
		rst        = 1'b0;
		run_checks = 1'b1;

		io_read(ADDR_BORDER, 1'b0);
		io_read(ADDR_SYSCONF, 1'b0);
		@(negedge fclk);
		check_border("border", border, '0);
		end_test("reset");

		for (int k = 0; k < 4; k++) begin
			rand_byte(v);
			io_write(ADDR_BORDER, v, 1'b0);
			@(negedge fclk);
			check_border("border", border, m_border);
			io_read(ADDR_BORDER, 1'b0);
			rand_byte(v);
			io_write(ADDR_SYSCONF, v, 1'b0);
			io_read(ADDR_SYSCONF, 1'b0);
		end
		end_test("readback");

		// beeper source while mux bit is clear
		io_write(ADDR_SYSCONF, 8'h00, 1'b0);
		for (int k = 0; k < 2; k++) begin
			rand_byte(v);
			v[`ZX_BEEPER_BIT] = (k == 0);
			io_write(ADDR_FE, v, 1'b0);
			@(negedge fclk);
			check_border("border", border, m_border);
			check_bit("beep", beep, m_beeper);
		end
		end_test("port_fe");

		for (int t = 0; t < 4; t++) begin
			check_clkz(zx_pkg::turbo_t'(t));
		end
		end_test("turbo");

		rand_byte(v);
		check_covox(v);
		check_covox(8'h80);
		end_test("covox");

		rand_byte(v);
		io_write(ADDR_BORDER, v, 1'b1);
		rand_byte(v);
		io_write(ADDR_SYSCONF, v, 1'b1);
		io_read(ADDR_BORDER, 1'b1);
		io_read(ADDR_FE, 1'b0);
		io_read(ADDR_COVOX, 1'b0);
		io_read(ADDR_UNUSED, 1'b0);
		rand_byte(v);
		io_write(ADDR_UNUSED, v, 1'b0);
		io_read(ADDR_BORDER, 1'b0);
		io_read(ADDR_SYSCONF, 1'b0);
		end_test("ignored");

		$display("%0d tests, %0d with errors, %0d errors in total", n_tests, n_bad, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// run limit
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge fclk);
			cycles++;
		end
		$display("timeout: tests still running after %0d fclk cycles", CYCLE_LIMIT);
		$display("Verification failed");
		$finish;
	end

endmodule

/* test/zx_top_sva.sv */
`timescale 1ns/1ps

module zx_top_sva (
	input logic fclk,
	input logic rst,
	input logic iord,
	input logic iowr_s,
	input logic d_ena,
	input logic beeper_mux,
	input logic beeper_bit,
	input logic beep
);

	// write strobe lasts one fclk cycle
	a_iowr_single: assert property (@(posedge fclk) disable iff (rst)
		iowr_s |=> !iowr_s)
		else $error("iowr_s high for two cycles in a row");

	// data only driven during a read
	a_dena_read: assert property (@(posedge fclk) disable iff (rst)
		d_ena |-> iord)
		else $error("d_ena high while iord is low");

	// beeper mode, beep is the port bit delayed by one cycle
	a_beep_follow: assert property (@(posedge fclk) disable iff (rst)
		!beeper_mux |=> (beep == $past(beeper_bit)))
		else $error("beep does not follow beeper_bit");

endmodule

bind zx_top zx_top_sva sva_i (
	.fclk       (fclk),
	.rst        (rst),
	.iord       (iord),
	.iowr_s     (iowr_s),
	.d_ena      (d_ena),
	.beeper_mux (beeper_mux),
	.beeper_bit (beeper_bit),
	.beep       (beep)
);
